// ==== build.f ====
rtl/rv_isa_pkg.sv
rtl/core_uarch_pkg.sv
rtl/fetch_unit.sv
rtl/decode_issue.sv
rtl/register_file.sv
rtl/alu_unit.sv
rtl/branch_unit.sv
rtl/rv_core.sv
dv/core_properties.sv
dv/core_checker.sv
dv/core_tb.sv

// ==== Makefile ====
# Verilator build and run of the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

FAIL_PATTERN := Verification failed
PASS_PATTERN := Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "$(FAIL_PATTERN)" $(LOG); then \
		echo "TEST FAILED: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_PATTERN)" $(LOG); then \
		echo "TEST FAILED: run ended early, see $(LOG)"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/core_tb.sv ====
`timescale 1ns/10ps

module core_tb;

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int PROG_LEN       = 67;

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_CUSTOM = 7'b0001011;

    logic        clk;
    logic        arst_n;
    logic        imem_en;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_value;
    logic        checker_done;
    int          pass_count;
    int          fail_count;

    logic [31:0] program_mem [PROG_LEN];

    ////////////////////
    // Instruction encoding

    function automatic logic [31:0] op_word(input logic [6:0] f7, input logic [2:0] f3,
                                            input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    function automatic logic [31:0] imm_word(input logic [6:0] opc, input logic [2:0] f3,
                                             input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] upper_word(input logic [6:0] opc, input int rd,
                                               input int imm);
        return {20'(imm), 5'(rd), opc};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input int rs1,
                                                input int rs2, input int offset);
        logic [12:0] b;
        b = 13'(offset);
        return {b[12], b[10:5], 5'(rs2), 5'(rs1), f3, b[4:1], b[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jump_word(input int rd, input int offset);
        logic [20:0] j;
        j = 21'(offset);
        return {j[20], j[10:1], j[11], j[19:12], 5'(rd), OPC_JAL};
    endfunction

    // Past the end of the program the memory holds a jump to itself
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [31:0] index;
        index = addr >> 2;
        if (index < PROG_LEN) begin
            return program_mem[index];
        end
        return jump_word(0, 0);
    endfunction

    ////////////////////
    // Program

    initial begin : load_program
        // Slots that must never retire, addi x31, x0, index
        for (int i = 0; i < PROG_LEN; i++) begin
            program_mem[i] = imm_word(OPC_OP_IMM, 3'b000, 31, 0, i);
        end
        // x1 = 5, x2 = -3
        program_mem[0]  = imm_word(OPC_OP_IMM, 3'b000, 1, 0, 5);
        program_mem[1]  = imm_word(OPC_OP_IMM, 3'b000, 2, 0, -3);
        // add, sub, and, or, xor, slt, sltu
        program_mem[2]  = op_word(7'h00, 3'b000, 3, 1, 2);
        program_mem[3]  = op_word(7'h20, 3'b000, 4, 1, 2);
        program_mem[4]  = op_word(7'h00, 3'b111, 5, 1, 2);
        program_mem[5]  = op_word(7'h00, 3'b110, 6, 1, 2);
        program_mem[6]  = op_word(7'h00, 3'b100, 7, 1, 2);
        program_mem[7]  = op_word(7'h00, 3'b010, 8, 2, 1);
        program_mem[8]  = op_word(7'h00, 3'b011, 9, 2, 1);
        // slli, srli, srai, then sll, sra, srl by x3
        program_mem[9]  = imm_word(OPC_OP_IMM, 3'b001, 10, 1, 4);
        program_mem[10] = imm_word(OPC_OP_IMM, 3'b101, 11, 2, 28);
        program_mem[11] = imm_word(OPC_OP_IMM, 3'b101, 12, 2, 'h401);
        program_mem[12] = op_word(7'h00, 3'b001, 13, 1, 3);
        program_mem[13] = op_word(7'h20, 3'b101, 14, 2, 3);
        program_mem[14] = op_word(7'h00, 3'b101, 15, 2, 3);
        // andi, ori, xori, slti, sltiu
        program_mem[15] = imm_word(OPC_OP_IMM, 3'b111, 16, 2, 'h0f0);
        program_mem[16] = imm_word(OPC_OP_IMM, 3'b110, 17, 1, 'h100);
        program_mem[17] = imm_word(OPC_OP_IMM, 3'b100, 18, 1, -1);
        program_mem[18] = imm_word(OPC_OP_IMM, 3'b010, 19, 2, -2);
        program_mem[19] = imm_word(OPC_OP_IMM, 3'b011, 20, 1, -1);
        // Dependent chain through x21..x24
        program_mem[20] = imm_word(OPC_OP_IMM, 3'b000, 21, 0, 7);
        program_mem[21] = op_word(7'h00, 3'b000, 21, 21, 21);
        program_mem[22] = imm_word(OPC_OP_IMM, 3'b000, 21, 21, 3);
        program_mem[23] = op_word(7'h20, 3'b000, 22, 21, 1);
        program_mem[24] = op_word(7'h00, 3'b100, 23, 22, 21);
        program_mem[25] = op_word(7'h00, 3'b000, 24, 23, 21);
        // lui, auipc, write to x0, read of x0, use of lui result
        program_mem[26] = upper_word(OPC_LUI, 25, 'h12345);
        program_mem[27] = upper_word(OPC_AUIPC, 26, 'h00001);
        program_mem[28] = imm_word(OPC_OP_IMM, 3'b000, 0, 1, 9);
        program_mem[29] = op_word(7'h00, 3'b000, 27, 0, 1);
        program_mem[30] = imm_word(OPC_OP_IMM, 3'b000, 28, 25, 'h678);
        // Each condition taken (+12) and not taken (+8)
        program_mem[31] = branch_word(3'b000, 1, 1, 12);
        program_mem[34] = branch_word(3'b000, 1, 2, 8);
        program_mem[35] = branch_word(3'b001, 1, 2, 12);
        program_mem[38] = branch_word(3'b001, 1, 1, 8);
        program_mem[39] = branch_word(3'b100, 2, 1, 12);
        program_mem[42] = branch_word(3'b100, 1, 2, 8);
        program_mem[43] = branch_word(3'b101, 1, 2, 12);
        program_mem[46] = branch_word(3'b101, 2, 1, 8);
        program_mem[47] = branch_word(3'b110, 1, 2, 12);
        program_mem[50] = branch_word(3'b110, 2, 1, 8);
        program_mem[51] = branch_word(3'b111, 2, 1, 12);
        program_mem[54] = branch_word(3'b111, 1, 2, 8);
        // jal, then jalr to 0x105 which lands on 0x104
        program_mem[55] = jump_word(29, 12);
        program_mem[58] = imm_word(OPC_OP_IMM, 3'b000, 30, 0, 'h100);
        program_mem[59] = imm_word(OPC_JALR, 3'b000, 31, 30, 5);
        // Unsupported opcode, then read the jalr link
        program_mem[65] = upper_word(OPC_CUSTOM, 5, 'h12345);
        program_mem[66] = imm_word(OPC_OP_IMM, 3'b000, 5, 31, 0);
    end

    ////////////////////
    // Clock and memory

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Word returns on the edge after the request
    initial begin : imem_model
        imem_data = '0;
        forever begin
            @(posedge clk);
            if (imem_en === 1'b1) begin
                imem_data <= word_at(imem_addr);
            end
        end
    end

    rv_core #(
        .RESET_VECTOR(32'h0000_0000)
    ) u_dut (
        .clk(clk),
        .arst_n(arst_n),
        .imem_en(imem_en),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .retire_valid(retire_valid),
        .retire_pc(retire_pc),
        .retire_rd(retire_rd),
        .retire_value(retire_value)
    );

    core_checker #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) u_checker (
        .clk(clk),
        .arst_n(arst_n),
        .retire_valid(u_dut.retire_valid),
        .retire_pc(u_dut.retire_pc),
        .retire_rd(u_dut.retire_rd),
        .retire_value(u_dut.retire_value),
        .done(checker_done),
        .pass_count(pass_count),
        .fail_count(fail_count)
    );

    ////////////////////
    // Reset and end of test

    initial begin : run
        int cycles;
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        cycles = 0;
        while (checker_done !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (checker_done !== 1'b1) begin
            $display("Timeout: not all instructions retired");
        end
        $display("Retire records: %0d passed, %0d failed; assertion failures: %0d",
                 pass_count, fail_count, u_dut.u_props.assert_fail_count);
        if (checker_done === 1'b1 && fail_count == 0 &&
            u_dut.u_props.assert_fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== dv/core_checker.sv ====
`timescale 1ns/10ps

module core_checker
    import rv_isa_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = 2000
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  retire_valid,
    input  logic [XLEN-1:0]       retire_pc,
    input  logic [REG_ADDR_W-1:0] retire_rd,
    input  logic [XLEN-1:0]       retire_value,
    output logic                  done,
    output int                    pass_count,
    output int                    fail_count
);

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
    } retire_rec_t;

    localparam int NUM_RECORDS = 49;

    // Retire order of the program in core_tb
    localparam retire_rec_t EXPECTED [NUM_RECORDS] = '{
        '{32'h0000_0000, 5'd1,  32'h0000_0005},
        '{32'h0000_0004, 5'd2,  32'hffff_fffd},
        '{32'h0000_0008, 5'd3,  32'h0000_0002},
        '{32'h0000_000c, 5'd4,  32'h0000_0008},
        '{32'h0000_0010, 5'd5,  32'h0000_0005},
        '{32'h0000_0014, 5'd6,  32'hffff_fffd},
        '{32'h0000_0018, 5'd7,  32'hffff_fff8},
        '{32'h0000_001c, 5'd8,  32'h0000_0001},
        '{32'h0000_0020, 5'd9,  32'h0000_0000},
        '{32'h0000_0024, 5'd10, 32'h0000_0050},
        '{32'h0000_0028, 5'd11, 32'h0000_000f},
        '{32'h0000_002c, 5'd12, 32'hffff_fffe},
        '{32'h0000_0030, 5'd13, 32'h0000_0014},
        '{32'h0000_0034, 5'd14, 32'hffff_ffff},
        '{32'h0000_0038, 5'd15, 32'h3fff_ffff},
        '{32'h0000_003c, 5'd16, 32'h0000_00f0},
        '{32'h0000_0040, 5'd17, 32'h0000_0105},
        '{32'h0000_0044, 5'd18, 32'hffff_fffa},
        '{32'h0000_0048, 5'd19, 32'h0000_0001},
        '{32'h0000_004c, 5'd20, 32'h0000_0001},
        // Dependent chain
        '{32'h0000_0050, 5'd21, 32'h0000_0007},
        '{32'h0000_0054, 5'd21, 32'h0000_000e},
        '{32'h0000_0058, 5'd21, 32'h0000_0011},
        '{32'h0000_005c, 5'd22, 32'h0000_000c},
        '{32'h0000_0060, 5'd23, 32'h0000_001d},
        '{32'h0000_0064, 5'd24, 32'h0000_002e},
        // Upper immediates and x0
        '{32'h0000_0068, 5'd25, 32'h1234_5000},
        '{32'h0000_006c, 5'd26, 32'h0000_106c},
        '{32'h0000_0070, 5'd0,  32'h0000_0000},
        '{32'h0000_0074, 5'd27, 32'h0000_0005},
        '{32'h0000_0078, 5'd28, 32'h1234_5678},
        // Branches, taken ones skip two slots
        '{32'h0000_007c, 5'd0,  32'h0000_0000},
        '{32'h0000_0088, 5'd0,  32'h0000_0000},
        '{32'h0000_008c, 5'd0,  32'h0000_0000},
        '{32'h0000_0098, 5'd0,  32'h0000_0000},
        '{32'h0000_009c, 5'd0,  32'h0000_0000},
        '{32'h0000_00a8, 5'd0,  32'h0000_0000},
        '{32'h0000_00ac, 5'd0,  32'h0000_0000},
        '{32'h0000_00b8, 5'd0,  32'h0000_0000},
        '{32'h0000_00bc, 5'd0,  32'h0000_0000},
        '{32'h0000_00c8, 5'd0,  32'h0000_0000},
        '{32'h0000_00cc, 5'd0,  32'h0000_0000},
        '{32'h0000_00d8, 5'd0,  32'h0000_0000},
        // Jumps write the link address
        '{32'h0000_00dc, 5'd29, 32'h0000_00e0},
        '{32'h0000_00e8, 5'd30, 32'h0000_0100},
        '{32'h0000_00ec, 5'd31, 32'h0000_00f0},
        // Unknown opcode, then first pass of the end loop
        '{32'h0000_0104, 5'd0,  32'h0000_0000},
        '{32'h0000_0108, 5'd5,  32'h0000_00f0},
        '{32'h0000_010c, 5'd0,  32'h0000_0000}
    };

    task automatic wait_for_retire(output logic seen);
        int cycles;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
            seen = (arst_n === 1'b1) && (retire_valid === 1'b1);
        end
    endtask

    // First wrong field decides the error line
    task automatic check_record(input int idx);
        retire_rec_t exp;
        exp = EXPECTED[idx];
        if (retire_pc !== exp.pc) begin
            $display("Error at time %0d ns: record %0d pc expected %h, actual %h",
                     $time, idx, exp.pc, retire_pc);
            fail_count++;
        end else if (retire_rd !== exp.rd) begin
            $display("Error at time %0d ns: record %0d rd expected %0d, actual %0d",
                     $time, idx, exp.rd, retire_rd);
            fail_count++;
        end else if (retire_value !== exp.value) begin
            $display("Error at time %0d ns: record %0d value expected %h, actual %h",
                     $time, idx, exp.value, retire_value);
            fail_count++;
        end else begin
            $display("Record %0d ok: pc %h rd x%0d value %h",
                     idx, retire_pc, retire_rd, retire_value);
            pass_count++;
        end
    endtask

    initial begin : walk_table
        logic seen;
        done       = 1'b0;
        pass_count = 0;
        fail_count = 0;
        seen       = 1'b0;
        for (int i = 0; i < NUM_RECORDS; i++) begin
            wait_for_retire(seen);
            if (!seen) begin
                $display("Checker stopped waiting: record %0d never retired", i);
                break;
            end
            check_record(i);
        end
        done <= seen;
    end

endmodule

// ==== dv/core_properties.sv ====
`timescale 1ns/10ps

module core_properties
    import rv_isa_pkg::*;
(
    input logic                  clk,
    input logic                  arst_n,
    input logic                  imem_en,
    input logic [XLEN-1:0]       imem_addr,
    input logic                  retire_valid,
    input logic [REG_ADDR_W-1:0] retire_rd,
    input logic [XLEN-1:0]       retire_value
);

    int assert_fail_count;

    initial begin
        assert_fail_count = 0;
    end

    // Fetch stays on word boundaries
    imem_word_aligned: assert property (
        @(posedge clk) disable iff (!arst_n) imem_en |-> imem_addr[1:0] == 2'b00
    ) else begin
        assert_fail_count++;
        $error("imem_addr %h is not word aligned", imem_addr);
    end

    rd_zero_value_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        retire_valid && retire_rd == '0 |-> retire_value == '0
    ) else begin
        assert_fail_count++;
        $error("retire with rd x0 carries value %h", retire_value);
    end

    retire_valid_known: assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown(retire_valid)
    ) else begin
        assert_fail_count++;
        $error("retire_valid is unknown after reset");
    end

endmodule

bind rv_core core_properties u_props (
    .clk(clk),
    .arst_n(arst_n),
    .imem_en(imem_en),
    .imem_addr(imem_addr),
    .retire_valid(retire_valid),
    .retire_rd(retire_rd),
    .retire_value(retire_value)
);

// ==== rtl/rv_core.sv ====
`timescale 1ns/10ps

module rv_core
    import rv_isa_pkg::*;
    import core_uarch_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_VECTOR = '0
) (
    input  logic                  clk,
    input  logic                  arst_n,

    output logic                  imem_en,
    output logic [XLEN-1:0]       imem_addr,
    input  logic [XLEN-1:0]       imem_data,

    output logic                  retire_valid,
    output logic [XLEN-1:0]       retire_pc,
    output logic [REG_ADDR_W-1:0] retire_rd,
    output logic [XLEN-1:0]       retire_value
);

    logic                  redirect;
    logic [XLEN-1:0]       redirect_pc;
    logic                  fetch_valid;
    logic [XLEN-1:0]       fetch_pc;
    logic [XLEN-1:0]       fetch_instr;
    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [XLEN-1:0]       rs1_data, rs2_data;
    logic                  issue_valid;
    logic [XLEN-1:0]       issue_pc;
    logic [REG_ADDR_W-1:0] issue_rd;
    alu_op_t               issue_alu_op;
    branch_op_t            issue_br_op;
    logic [XLEN-1:0]       issue_a, issue_b, issue_imm;
    logic                  ex_valid;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [XLEN-1:0]       ex_result;
    logic                  rf_wr_en;

    // Retire record doubles as the register write port
    assign rf_wr_en = retire_valid & (retire_rd != '0);

    ////////////////////
    // Front end

    fetch_unit #(.RESET_VECTOR(RESET_VECTOR)) u_fetch (
        .clk(clk), .arst_n(arst_n),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .imem_en(imem_en), .imem_addr(imem_addr), .imem_data(imem_data),
        .fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_instr(fetch_instr)
    );

    decode_issue u_decode (
        .clk(clk), .arst_n(arst_n),
        .fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_instr(fetch_instr),
        .redirect(redirect),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex_valid(ex_valid), .ex_rd(ex_rd), .ex_result(ex_result),
        .issue_valid(issue_valid), .issue_pc(issue_pc), .issue_rd(issue_rd),
        .issue_alu_op(issue_alu_op), .issue_br_op(issue_br_op),
        .issue_a(issue_a), .issue_b(issue_b), .issue_imm(issue_imm)
    );

    register_file u_regfile (
        .clk(clk), .arst_n(arst_n),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(rf_wr_en), .wr_addr(retire_rd), .wr_data(retire_value)
    );

    ////////////////////
    // Execute

    alu_unit u_alu (
        .clk(clk), .arst_n(arst_n),
        .issue_valid(issue_valid), .issue_pc(issue_pc), .issue_rd(issue_rd),
        .issue_alu_op(issue_alu_op), .issue_a(issue_a), .issue_b(issue_b),
        .ex_valid(ex_valid), .ex_rd(ex_rd), .ex_result(ex_result),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_value(retire_value)
    );

    branch_unit u_branch (
        .issue_valid(issue_valid), .issue_br_op(issue_br_op),
        .issue_a(issue_a), .issue_b(issue_b),
        .issue_pc(issue_pc), .issue_imm(issue_imm),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

endmodule

// ==== rtl/branch_unit.sv ====
`timescale 1ns/10ps

module branch_unit
    import rv_isa_pkg::*;
    import core_uarch_pkg::*;
(
    input  logic            issue_valid,
    input  branch_op_t      issue_br_op,
    input  logic [XLEN-1:0] issue_a,
    input  logic [XLEN-1:0] issue_b,
    input  logic [XLEN-1:0] issue_pc,
    input  logic [XLEN-1:0] issue_imm,

    output logic            redirect,
    output logic [XLEN-1:0] redirect_pc
);

    logic            eq;
    logic            lt;
    logic            ltu;
    logic            taken;
    logic [XLEN-1:0] jalr_sum;

    ////////////////////
    // Condition

    assign eq  = (issue_a == issue_b);
    assign lt  = ($signed(issue_a) < $signed(issue_b));
    assign ltu = (issue_a < issue_b);

    always_comb begin
        case (issue_br_op)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = ~eq;
            BR_BLT:  taken = lt;
            BR_BGE:  taken = ~lt;
            BR_BLTU: taken = ltu;
            BR_BGEU: taken = ~ltu;
            BR_JAL,
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    ////////////////////
    // Target

    assign jalr_sum = issue_a + issue_imm;

    // jalr drops bit 0 of the sum
    assign redirect_pc = (issue_br_op == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                                  : issue_pc + issue_imm;
    assign redirect    = issue_valid & taken;

endmodule

// ==== rtl/alu_unit.sv ====
`timescale 1ns/10ps

module alu_unit
    import rv_isa_pkg::*;
    import core_uarch_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    input  logic                  issue_valid,
    input  logic [XLEN-1:0]       issue_pc,
    input  logic [REG_ADDR_W-1:0] issue_rd,
    input  alu_op_t               issue_alu_op,
    input  logic [XLEN-1:0]       issue_a,
    input  logic [XLEN-1:0]       issue_b,

    output logic                  ex_valid,
    output logic [REG_ADDR_W-1:0] ex_rd,
    output logic [XLEN-1:0]       ex_result,

    output logic                  retire_valid,
    output logic [XLEN-1:0]       retire_pc,
    output logic [REG_ADDR_W-1:0] retire_rd,
    output logic [XLEN-1:0]       retire_value
);

    logic [XLEN-1:0] alu_result;
    logic [4:0]      shamt;

    assign shamt = issue_b[4:0];

    always_comb begin
        case (issue_alu_op)
            ALU_ADD:    alu_result = issue_a + issue_b;
            ALU_SUB:    alu_result = issue_a - issue_b;
            ALU_AND:    alu_result = issue_a & issue_b;
            ALU_OR:     alu_result = issue_a | issue_b;
            ALU_XOR:    alu_result = issue_a ^ issue_b;
            ALU_SLT:    alu_result = XLEN'($signed(issue_a) < $signed(issue_b));
            ALU_SLTU:   alu_result = XLEN'(issue_a < issue_b);
            ALU_SLL:    alu_result = issue_a << shamt;
            ALU_SRL:    alu_result = issue_a >> shamt;
            ALU_SRA:    alu_result = $unsigned($signed(issue_a) >>> shamt);
            ALU_PASS_B: alu_result = issue_b;
            ALU_LINK:   alu_result = issue_pc + XLEN'(4);
            default:    alu_result = '0;
        endcase
    end

    // Execute-stage result for forwarding in decode
    assign ex_valid  = issue_valid;
    assign ex_rd     = issue_rd;
    assign ex_result = alu_result;

    ////////////////////
    // Retire register

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        retire_pc    <= issue_pc;
        retire_rd    <= issue_rd;
        retire_value <= (issue_rd == '0) ? '0 : alu_result;
    end

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/10ps

module register_file (
    input  logic        clk,
    input  logic        arst_n,

    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,

    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Same-cycle write is visible to the reader
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (wr_en && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (wr_en && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

endmodule

// ==== rtl/decode_issue.sv ====
`timescale 1ns/10ps

module decode_issue
    import rv_isa_pkg::*;
    import core_uarch_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    input  logic                  fetch_valid,
    input  logic [XLEN-1:0]       fetch_pc,
    input  logic [XLEN-1:0]       fetch_instr,
    input  logic                  redirect,

    output logic [REG_ADDR_W-1:0] rs1_addr,
    output logic [REG_ADDR_W-1:0] rs2_addr,
    input  logic [XLEN-1:0]       rs1_data,
    input  logic [XLEN-1:0]       rs2_data,

    input  logic                  ex_valid,
    input  logic [REG_ADDR_W-1:0] ex_rd,
    input  logic [XLEN-1:0]       ex_result,

    output logic                  issue_valid,
    output logic [XLEN-1:0]       issue_pc,
    output logic [REG_ADDR_W-1:0] issue_rd,
    output alu_op_t               issue_alu_op,
    output branch_op_t            issue_br_op,
    output logic [XLEN-1:0]       issue_a,
    output logic [XLEN-1:0]       issue_b,
    output logic [XLEN-1:0]       issue_imm
);

    opcode_t               opcode;
    logic [2:0]            funct3;
    logic                  alt;
    logic [REG_ADDR_W-1:0] rd_field;
    logic [XLEN-1:0]       imm_i, imm_u, imm_b, imm_j;
    logic [XLEN-1:0]       rs1_fwd, rs2_fwd;
    logic [REG_ADDR_W-1:0] dec_rd;
    alu_op_t               dec_alu_op;
    branch_op_t            dec_br_op;
    logic [XLEN-1:0]       dec_imm;
    op_a_sel_t             a_sel;
    op_b_sel_t             b_sel;

    function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic sel_alt);
        case (f3)
            F3_ADD_SUB: return sel_alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return sel_alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    ////////////////////
    // Fields and immediates

    assign opcode   = opcode_t'(fetch_instr[OPCODE_W-1:0]);
    assign funct3   = fetch_instr[FUNCT3_LSB +: 3];
    assign alt      = fetch_instr[FUNCT7_ALT];
    assign rd_field = fetch_instr[RD_LSB +: REG_ADDR_W];
    assign rs1_addr = fetch_instr[RS1_LSB +: REG_ADDR_W];
    assign rs2_addr = fetch_instr[RS2_LSB +: REG_ADDR_W];

    assign imm_i = {{20{fetch_instr[31]}}, fetch_instr[31:20]};
    assign imm_u = {fetch_instr[31:12], 12'b0};
    assign imm_b = {{19{fetch_instr[31]}}, fetch_instr[31], fetch_instr[7],
                    fetch_instr[30:25], fetch_instr[11:8], 1'b0};
    assign imm_j = {{11{fetch_instr[31]}}, fetch_instr[31], fetch_instr[19:12],
                    fetch_instr[20], fetch_instr[30:21], 1'b0};

    ////////////////////
    // Operation decode

    always_comb begin
        dec_rd     = rd_field;
        dec_alu_op = ALU_ADD;
        dec_br_op  = BR_NONE;
        dec_imm    = imm_i;
        a_sel      = A_SEL_RS1;
        b_sel      = B_SEL_RS2;
        case (opcode)
            OPC_OP: begin
                dec_alu_op = alu_decode(funct3, alt);
            end
            OPC_OP_IMM: begin
                // Bit 30 is immediate data except for srai
                dec_alu_op = alu_decode(funct3, alt && (funct3 == F3_SRL_SRA));
                b_sel      = B_SEL_IMM;
            end
            OPC_LUI: begin
                dec_alu_op = ALU_PASS_B;
                dec_imm    = imm_u;
                b_sel      = B_SEL_IMM;
            end
            OPC_AUIPC: begin
                dec_imm = imm_u;
                a_sel   = A_SEL_PC;
                b_sel   = B_SEL_IMM;
            end
            OPC_BRANCH: begin
                dec_rd  = '0;
                dec_imm = imm_b;
                case (funct3)
                    F3_BEQ:  dec_br_op = BR_BEQ;
                    F3_BNE:  dec_br_op = BR_BNE;
                    F3_BLT:  dec_br_op = BR_BLT;
                    F3_BGE:  dec_br_op = BR_BGE;
                    F3_BLTU: dec_br_op = BR_BLTU;
                    F3_BGEU: dec_br_op = BR_BGEU;
                    default: dec_br_op = BR_NONE;
                endcase
            end
            OPC_JAL: begin
                dec_alu_op = ALU_LINK;
                dec_br_op  = BR_JAL;
                dec_imm    = imm_j;
            end
            OPC_JALR: begin
                dec_alu_op = ALU_LINK;
                dec_br_op  = BR_JALR;
            end
            // Unsupported, retires as a no-op
            default: dec_rd = '0;
        endcase
    end

    ////////////////////
    // Operand forwarding

    // Execute result first; the register file covers the retire stage
    assign rs1_fwd = (ex_valid && ex_rd != '0 && ex_rd == rs1_addr) ? ex_result : rs1_data;
    assign rs2_fwd = (ex_valid && ex_rd != '0 && ex_rd == rs2_addr) ? ex_result : rs2_data;

    ////////////////////
    // Issue register

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= fetch_valid & ~redirect;
        end
    end

    always_ff @(posedge clk) begin
        issue_pc     <= fetch_pc;
        issue_rd     <= dec_rd;
        issue_alu_op <= dec_alu_op;
        issue_br_op  <= dec_br_op;
        issue_imm    <= dec_imm;
        issue_a      <= (a_sel == A_SEL_PC) ? fetch_pc : rs1_fwd;
        issue_b      <= (b_sel == B_SEL_IMM) ? dec_imm : rs2_fwd;
    end

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit
    import rv_isa_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_VECTOR = '0
) (
    input  logic            clk,
    input  logic            arst_n,

    input  logic            redirect,
    input  logic [XLEN-1:0] redirect_pc,

    output logic            imem_en,
    output logic [XLEN-1:0] imem_addr,
    input  logic [XLEN-1:0] imem_data,

    output logic            fetch_valid,
    output logic [XLEN-1:0] fetch_pc,
    output logic [XLEN-1:0] fetch_instr
);

    logic [XLEN-1:0] pc;
    logic            fetch_active;

    ////////////////////
    // Program counter

    // Requests start one cycle after reset release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc           <= RESET_VECTOR;
            fetch_active <= 1'b0;
        end else begin
            fetch_active <= 1'b1;
            if (redirect) begin
                pc <= redirect_pc;
            end else if (fetch_active) begin
                pc <= pc + XLEN'(4);
            end
        end
    end

    assign imem_en   = fetch_active;
    assign imem_addr = pc;

    ////////////////////
    // Returning word

    // A redirect drops the word still in flight
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= imem_en & ~redirect;
        end
    end

    // pc of the request, paired with the word one cycle later
    always_ff @(posedge clk) begin
        fetch_pc <= pc;
    end

    assign fetch_instr = imem_data;

endmodule

// ==== rtl/core_uarch_pkg.sv ====
package core_uarch_pkg;

    // Operations carried by the issue register to the ALU
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B,  // lui
        ALU_LINK     // pc + 4 for jal and jalr
    } alu_op_t;

    // Branch unit operations
    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } branch_op_t;

    // Operand sources in decode
    typedef enum logic {A_SEL_RS1, A_SEL_PC} op_a_sel_t;
    typedef enum logic {B_SEL_RS2, B_SEL_IMM} op_b_sel_t;

endpackage

// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    ////////////////////
    // Widths

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;

    ////////////////////
    // Major opcodes kept by the core

    typedef enum logic [OPCODE_W-1:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_t;

    ////////////////////
    // funct3 codes

    // Register and immediate ALU group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Conditional branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Instruction bit 30, selects sub and sra
    localparam int FUNCT7_ALT = 30;

    ////////////////////
    // Field positions

    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;

endpackage
